/* Bender.yml */
package:
  name: cache_top

sources:
  - rtl/cache_pkg.sv
  - rtl/cache_data_array.sv
  - rtl/cache_tag_array.sv
  - rtl/cache_read_channel.sv
  - rtl/cache_controller.sv
  - rtl/cache_top.sv
  - target: test
    files:
      - verification/backend_mem_model.sv
      - verification/tb_cache_top.sv

/* cache_top.f */
rtl/cache_pkg.sv
rtl/cache_data_array.sv
rtl/cache_tag_array.sv
rtl/cache_read_channel.sv
rtl/cache_controller.sv
rtl/cache_top.sv
verification/backend_mem_model.sv
verification/tb_cache_top.sv

/* rtl/cache_controller.sv */
module cache_controller (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                req,
    input  cache_pkg::fe_req_t                  fe_req,
    output logic                                ack,
    output cache_pkg::fe_resp_t                 fe_resp,
    output logic [cache_pkg::index_w-1:0]       rd_index,
    output logic [cache_pkg::word_offset_w-1:0] rd_word,
    input  logic                                rd_valid,
    input  logic [cache_pkg::tag_w-1:0]         rd_tag,
    input  logic [cache_pkg::data_w-1:0]        rd_data,
    output logic                                tag_we,
    output cache_pkg::line_addr_t               tag_wr,
    output logic                                replace_valid,
    output cache_pkg::line_addr_t               replace_addr,
    input  logic                                replace
);

    cache_pkg::ctrl_state_e state;
    logic                   hit;

    // fe_req is stable while req is high, so the array address comes from it
    assign rd_index = fe_req.index;
    assign rd_word  = fe_req.word_offset;

    assign hit = rd_valid && (rd_tag == fe_req.tag);

    assign replace_valid      = (state == cache_pkg::ctrl_compare) && !hit;    // one cycle
    assign replace_addr.tag   = fe_req.tag;
    assign replace_addr.index = fe_req.index;

    // the channel raises replace in the first refill cycle, so its fall means done
    assign tag_we       = (state == cache_pkg::ctrl_refill) && !replace;
    assign tag_wr.tag   = fe_req.tag;
    assign tag_wr.index = fe_req.index;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= cache_pkg::ctrl_idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                cache_pkg::ctrl_idle: begin
                    if (req)
                        state <= cache_pkg::ctrl_lookup;
                end
                cache_pkg::ctrl_lookup: begin
                    state <= cache_pkg::ctrl_compare;    // arrays read this cycle
                end
                cache_pkg::ctrl_compare: begin
                    if (hit)
                        state <= cache_pkg::ctrl_respond;
                    else
                        state <= cache_pkg::ctrl_refill;
                end
                cache_pkg::ctrl_refill: begin
                    if (!replace)
                        state <= cache_pkg::ctrl_lookup; // retry, now a hit
                end
                cache_pkg::ctrl_respond: begin
                    ack   <= 1'b1;
                    state <= cache_pkg::ctrl_release;
                end
                cache_pkg::ctrl_release: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= cache_pkg::ctrl_idle;
                    end
                end
                default: state <= cache_pkg::ctrl_idle;
            endcase
        end
    end

    // read data held for the front end until the next hit
    always_ff @(posedge clk) begin
        if (state == cache_pkg::ctrl_compare && hit)
            fe_resp.data <= rd_data;
    end

endmodule

/* rtl/cache_data_array.sv */
module cache_data_array (
    input  logic                                clk,
    input  logic [cache_pkg::index_w-1:0]       rd_index,
    input  logic [cache_pkg::word_offset_w-1:0] rd_word,
    input  logic                                refill_we,
    input  cache_pkg::refill_word_t             refill,
    output logic [cache_pkg::data_w-1:0]        rd_data
);

    localparam int depth = cache_pkg::num_lines * cache_pkg::words_per_line;
    localparam int ptr_w = cache_pkg::index_w + cache_pkg::word_offset_w;

    logic [cache_pkg::data_w-1:0]   mem [depth];
    logic [ptr_w-1:0]               rd_ptr;
    logic [ptr_w-1:0]               wr_ptr;

    // word address is line index followed by word offset
    assign rd_ptr = {rd_index, rd_word};
    assign wr_ptr = {refill.index, refill.word_offset};

    always_ff @(posedge clk) begin
        if (refill_we)
            mem[wr_ptr] <= refill.data;     // refill port only
        rd_data <= mem[rd_ptr];
    end

endmodule

/* rtl/cache_pkg.sv */
package cache_pkg;

    localparam int addr_w         = 16;                 // byte address
    localparam int data_w         = 32;                 // front and back end word
    localparam int byte_offset_w  = 2;                  // byte within word
    localparam int word_offset_w  = 2;                  // word within line
    localparam int words_per_line = 1 << word_offset_w;
    localparam int index_w        = 3;                  // line select
    localparam int num_lines      = 1 << index_w;
    localparam int tag_w          = addr_w - index_w - word_offset_w - byte_offset_w;

    // front end read request, laid out as the byte address
    typedef struct packed {
        logic [tag_w-1:0]         tag;
        logic [index_w-1:0]       index;
        logic [word_offset_w-1:0] word_offset;
        logic [byte_offset_w-1:0] byte_offset;
    } fe_req_t;

    typedef struct packed {
        logic [data_w-1:0] data;
    } fe_resp_t;

    // identifies one line, used for refill and tag update
    typedef struct packed {
        logic [tag_w-1:0]   tag;
        logic [index_w-1:0] index;
    } line_addr_t;

    typedef struct packed {
        logic [index_w-1:0]       index;
        logic [word_offset_w-1:0] word_offset;
        logic [data_w-1:0]        data;
    } refill_word_t;

    typedef enum logic [2:0] {
        ctrl_idle,
        ctrl_lookup,
        ctrl_compare,
        ctrl_refill,
        ctrl_respond,
        ctrl_release
    } ctrl_state_e;

    typedef enum logic [1:0] {
        rf_idle,
        rf_handshake,
        rf_end_handshake        // one extra cycle after the last beat
    } refill_state_e;

endpackage

/* rtl/cache_read_channel.sv */
module cache_read_channel (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            replace_valid,
    input  cache_pkg::line_addr_t           replace_addr,
    output logic                            replace,
    output logic                            mem_valid,
    output logic [cache_pkg::addr_w-1:0]    mem_addr,
    input  logic                            mem_ready,
    input  logic [cache_pkg::data_w-1:0]    mem_rdata,
    output logic                            refill_we,
    output cache_pkg::refill_word_t         refill
);

    cache_pkg::refill_state_e               state;
    cache_pkg::line_addr_t                  line_q;     // line being fetched
    logic [cache_pkg::word_offset_w-1:0]    word_cnt;   // next word to request
    logic                                   beat;

    assign beat = mem_valid & mem_ready;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state    <= cache_pkg::rf_idle;
            word_cnt <= '0;
        end else begin
            case (state)
                cache_pkg::rf_idle: begin
                    word_cnt <= '0;
                    if (replace_valid)
                        state <= cache_pkg::rf_handshake;
                end
                cache_pkg::rf_handshake: begin
                    if (beat) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (&word_cnt)              // last word of the line accepted
                            state <= cache_pkg::rf_end_handshake;
                    end
                end
                cache_pkg::rf_end_handshake: begin
                    state <= cache_pkg::rf_idle;
                end
                default: state <= cache_pkg::rf_idle;
            endcase
        end
    end

    // capture the line so the controller need not hold it
    always_ff @(posedge clk) begin
        if (state == cache_pkg::rf_idle && replace_valid)
            line_q <= replace_addr;
    end

    assign replace   = (state != cache_pkg::rf_idle);
    assign mem_valid = (state == cache_pkg::rf_handshake);
    assign mem_addr  = {line_q, word_cnt, {cache_pkg::byte_offset_w{1'b0}}};

    // each accepted beat goes straight into the data array
    assign refill_we          = beat;
    assign refill.index       = line_q.index;
    assign refill.word_offset = word_cnt;
    assign refill.data        = mem_rdata;

endmodule

/* rtl/cache_tag_array.sv */
module cache_tag_array (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cache_pkg::index_w-1:0]   rd_index,
    input  logic                            tag_we,
    input  cache_pkg::line_addr_t           tag_wr,
    output logic                            rd_valid,
    output logic [cache_pkg::tag_w-1:0]     rd_tag
);

    logic [cache_pkg::num_lines-1:0]    valid;                          // one bit per line
    logic [cache_pkg::tag_w-1:0]        tags [cache_pkg::num_lines];

    // valid bits are the only state cleared by reset
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            valid    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (tag_we)
                valid[tag_wr.index] <= 1'b1;
            rd_valid <= valid[rd_index];    // registered read
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we)
            tags[tag_wr.index] <= tag_wr.tag;
        rd_tag <= tags[rd_index];
    end

endmodule

/* rtl/cache_top.sv */
module cache_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            req,
    input  cache_pkg::fe_req_t              fe_req,
    output logic                            ack,
    output cache_pkg::fe_resp_t             fe_resp,
    output logic                            mem_valid,
    output logic [cache_pkg::addr_w-1:0]    mem_addr,
    input  logic                            mem_ready,
    input  logic [cache_pkg::data_w-1:0]    mem_rdata
);

    logic [cache_pkg::index_w-1:0]          rd_index;
    logic [cache_pkg::word_offset_w-1:0]    rd_word;
    logic                                   rd_valid;
    logic [cache_pkg::tag_w-1:0]            rd_tag;
    logic [cache_pkg::data_w-1:0]           rd_data;
    logic                                   tag_we;
    cache_pkg::line_addr_t                  tag_wr;
    logic                                   replace_valid;
    cache_pkg::line_addr_t                  replace_addr;
    logic                                   replace;
    logic                                   refill_we;
    cache_pkg::refill_word_t                refill;

    cache_controller i_controller (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .fe_req        (fe_req),
        .ack           (ack),
        .fe_resp       (fe_resp),
        .rd_index      (rd_index),
        .rd_word       (rd_word),
        .rd_valid      (rd_valid),
        .rd_tag        (rd_tag),
        .rd_data       (rd_data),
        .tag_we        (tag_we),
        .tag_wr        (tag_wr),
        .replace_valid (replace_valid),
        .replace_addr  (replace_addr),
        .replace       (replace)
    );

    cache_tag_array i_tag_array (
        .clk      (clk),
        .reset    (reset),
        .rd_index (rd_index),
        .tag_we   (tag_we),
        .tag_wr   (tag_wr),
        .rd_valid (rd_valid),
        .rd_tag   (rd_tag)
    );

    cache_data_array i_data_array (
        .clk       (clk),
        .rd_index  (rd_index),
        .rd_word   (rd_word),
        .refill_we (refill_we),
        .refill    (refill),
        .rd_data   (rd_data)
    );

    cache_read_channel i_read_channel (
        .clk           (clk),
        .reset         (reset),
        .replace_valid (replace_valid),
        .replace_addr  (replace_addr),
        .replace       (replace),
        .mem_valid     (mem_valid),
        .mem_addr      (mem_addr),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .refill_we     (refill_we),
        .refill        (refill)
    );

endmodule

/* verification/backend_mem_model.sv */
module backend_mem_model #(
    parameter logic [31:0] seed         = 32'h1,
    parameter logic [31:0] data_pattern = 32'h0
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            mem_valid,
    input  logic [cache_pkg::addr_w-1:0]    mem_addr,
    output logic                            mem_ready,
    output logic [cache_pkg::data_w-1:0]    mem_rdata,
    output logic                            beat_done,     // a beat completed last cycle
    output logic [cache_pkg::addr_w-1:0]    beat_addr      // address of that beat
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] lfsr_state;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // word at an address is the byte address xor a fixed pattern
    assign mem_rdata = {{(cache_pkg::data_w - cache_pkg::addr_w){1'b0}}, mem_addr} ^ data_pattern;

    always @(posedge clk or posedge reset) begin
        logic [31:0] s1;
        logic [31:0] s2;
        if (reset) begin
            lfsr_state <= seed;
            mem_ready  <= 1'b0;
            beat_done  <= 1'b0;
            beat_addr  <= '0;
        end else begin
            s1 = lfsr_step(lfsr_state);
            s2 = lfsr_step(s1);
            lfsr_state <= s2;
            mem_ready  <= s1[0] | s2[0];                   // ready about three cycles in four
            beat_done  <= mem_valid & mem_ready;
            if (mem_valid && mem_ready)
                beat_addr <= mem_addr;
        end
    end

endmodule

/* verification/tb_cache_top.sv */
module tb_cache_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          num_requests        = 300;
    localparam int          max_cycles_per_req  = 40;     // miss with long back end stalls
    localparam int          reset_cycles        = 8;
    localparam int          cycle_limit         = reset_cycles + 4 +
                                                  num_requests * max_cycles_per_req;
    localparam logic [31:0] data_pattern        = 32'h5a3c_96e1;
    localparam logic [31:0] lfsr_seed           = 32'h46da_5ade;

    logic                               clk;
    logic                               reset;
    logic                               req;
    cache_pkg::fe_req_t                 fe_req;
    logic                               ack;
    cache_pkg::fe_resp_t                fe_resp;
    logic                               mem_valid;
    logic [cache_pkg::addr_w-1:0]       mem_addr;
    logic                               mem_ready;
    logic [cache_pkg::data_w-1:0]       mem_rdata;
    logic                               beat_done;
    logic [cache_pkg::addr_w-1:0]       beat_addr;

    logic [31:0]                        lfsr_state = lfsr_seed;
    logic                               model_valid [cache_pkg::num_lines];
    logic [cache_pkg::tag_w-1:0]        model_tag   [cache_pkg::num_lines];
    logic [cache_pkg::addr_w-1:0]       beat_q [$];
    int                                 expected_refills = 0;
    int                                 refills = 0;        // rising edges of mem_valid
    int                                 valid_cycles = 0;   // cycles with mem_valid high
    int                                 cycle_count = 0;
    logic                               mem_valid_q = 1'b0;
    logic                               stall_q = 1'b0;
    logic [cache_pkg::addr_w-1:0]       stall_addr_q = '0;

    cache_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .fe_req    (fe_req),
        .ack       (ack),
        .fe_resp   (fe_resp),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    backend_mem_model #(
        .seed         (lfsr_seed),
        .data_pattern (data_pattern)
    ) i_mem (
        .clk       (clk),
        .reset     (reset),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .beat_done (beat_done),
        .beat_addr (beat_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_resp(input cache_pkg::fe_resp_t got, input cache_pkg::fe_resp_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch fe_resp: got %h expected %h", got, exp));
    endtask

    task automatic check_addr(input logic [cache_pkg::addr_w-1:0] got,
                              input logic [cache_pkg::addr_w-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("mismatch mem_addr: got %h expected %h", got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // mostly two tags per index, so hits, misses and evictions all happen
    function automatic cache_pkg::fe_req_t random_request();
        cache_pkg::fe_req_t r;
        logic [31:0]        bits;
        bits = take_bits(3);
        if (bits[2:0] == 3'd0)
            bits = take_bits(cache_pkg::tag_w);
        else
            bits = take_bits(1);
        r.tag         = bits[cache_pkg::tag_w-1:0];
        bits          = take_bits(cache_pkg::index_w + 4);
        r.index       = bits[cache_pkg::index_w+3:4];
        r.word_offset = bits[3:2];
        r.byte_offset = bits[1:0];
        return r;
    endfunction

    function automatic cache_pkg::fe_resp_t expected_word(input cache_pkg::fe_req_t a);
        cache_pkg::fe_resp_t w;
        w.data = {16'h0, a.tag, a.index, a.word_offset, 2'b00} ^ data_pattern;
        return w;
    endfunction

    // called on a rising edge with the cache idle
    task automatic run_request(input cache_pkg::fe_req_t a);
        logic                           hit_exp;
        int                             n;
        int                             valid_before;
        logic [cache_pkg::addr_w-1:0]   base;
        hit_exp      = model_valid[a.index] && (model_tag[a.index] == a.tag);
        base         = {a.tag, a.index, 4'b0000};
        valid_before = valid_cycles;
        beat_q.delete();
        req    <= 1'b1;
        fe_req <= a;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!ack);
        check_resp(fe_resp, expected_word(a));
        if (hit_exp)
            check_count("ack latency", n, 5);   // set 3 edges after req is sampled and seen one edge later
        req <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (ack);
        check_count("ack release", n, 2);
        if (hit_exp) begin
            check_count("mem_valid cycles", valid_cycles - valid_before, 0);
        end else begin
            check_count("beats", beat_q.size(), 4);
            for (int i = 0; i < 4; i++)
                check_addr(beat_q[i], base + 16'(i * 4));
            model_valid[a.index] = 1'b1;
            model_tag[a.index]   = a.tag;
            expected_refills++;
        end
        check_count("refills", refills, expected_refills);
    endtask

    // back end monitor for the stall rule and the beat log
    always @(posedge clk) begin
        if (stall_q) begin
            if (!mem_valid)
                report_failure("mem_valid dropped while the back end was stalling");
            check_addr(mem_addr, stall_addr_q);
        end
        if (beat_done)
            beat_q.push_back(beat_addr);
        if (mem_valid)
            valid_cycles <= valid_cycles + 1;
        if (mem_valid && !mem_valid_q)
            refills <= refills + 1;
        mem_valid_q  <= mem_valid;
        stall_q      <= mem_valid && !mem_ready;
        stall_addr_q <= mem_addr;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
            report_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
    end

    initial begin
        logic [cache_pkg::addr_w-1:0] directed [4];
        reset  = 1'b1;
        req    = 1'b0;
        fe_req = '0;
        for (int i = 0; i < cache_pkg::num_lines; i++)
            model_valid[i] = 1'b0;
        // two tags on index 2 where the first is evicted and read back
        directed[0] = 16'h0024;
        directed[1] = 16'h0224;
        directed[2] = 16'h0024;
        directed[3] = 16'h0028;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin
            @(posedge clk);
            check_level("ack", ack, 1'b0);
            check_level("mem_valid", mem_valid, 1'b0);
        end
        for (int i = 0; i < 4; i++)
            run_request(cache_pkg::fe_req_t'(directed[i]));
        for (int i = 4; i < num_requests; i++)
            run_request(random_request());
        $display("Test completed successfully");
        $finish;
    end

endmodule
